/* mul_params.svh */
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// operand width in bits
`define MUL_XLEN 32

// radix-4 digits needed for a 34-bit extended multiplier
`define MUL_PP_COUNT 17

// register stages from the input strobe to the result
`define MUL_PIPE_DEPTH 5

`endif

/* mul_pkg.sv */
`include "mul_params.svh"

package mul_pkg;

  // one source operand
  typedef logic [`MUL_XLEN-1:0] operand_t;
  // full double-width product
  typedef logic [2*`MUL_XLEN-1:0] product_t;
  // partial product or compressor output row, same width as the product
  typedef logic [2*`MUL_XLEN-1:0] pp_row_t;

  localparam int PP_COUNT = `MUL_PP_COUNT;

endpackage

/* mul_booth_r4.sv */
`include "mul_params.svh"

module mul_booth_r4 (
  input  logic                                        rs1_signed_i,
  input  logic                                        rs2_signed_i,
  input  mul_pkg::operand_t                           rs1_i,
  input  mul_pkg::operand_t                           rs2_i,
  output mul_pkg::pp_row_t [`MUL_PP_COUNT-1:0]        pp_o
);

  // operands widened by two bits so unsigned values stay positive
  logic [`MUL_XLEN+1:0] a_ext;
  logic [`MUL_XLEN+1:0] b_ext;
  // multiplier with the implicit zero below bit 0
  logic [`MUL_XLEN+2:0] b_scan;
  // multiplicand sign-extended to the full row width
  mul_pkg::pp_row_t     a_wide;

  assign a_ext  = {{2{rs1_signed_i & rs1_i[`MUL_XLEN-1]}}, rs1_i};
  assign b_ext  = {{2{rs2_signed_i & rs2_i[`MUL_XLEN-1]}}, rs2_i};
  assign b_scan = {b_ext, 1'b0};
  assign a_wide = {{(`MUL_XLEN-2){a_ext[`MUL_XLEN+1]}}, a_ext};

  for (genvar i = 0; i < `MUL_PP_COUNT; i++) begin : g_row
    logic [2:0]       grp;
    logic             sel_one;
    logic             sel_two;
    logic             neg;
    mul_pkg::pp_row_t mag;
    mul_pkg::pp_row_t row;

    // overlapping 3-bit window, digit in -2..+2
    assign grp = b_scan[2*i +: 3];

    // 001, 010, 101, 110 select one times the multiplicand
    assign sel_one = grp[0] ^ grp[1];
    // 011 and 100 select two times
    assign sel_two = (grp == 3'b011) | (grp == 3'b100);
    // 111 also sets neg, but mag is zero there
    assign neg     = grp[2];

    always_comb begin
      if (sel_one) begin
        mag = a_wide;
      end else if (sel_two) begin
        mag = a_wide << 1;
      end else begin
        mag = '0;
      end
    end

    assign row = neg ? (~mag + 1'b1) : mag;

    // weight of digit i is 4^i
    assign pp_o[i] = row << (2 * i);
  end

endmodule

/* mul_csa_row42.sv */
module mul_csa_row42 (
  input  mul_pkg::pp_row_t x0_i,
  input  mul_pkg::pp_row_t x1_i,
  input  mul_pkg::pp_row_t x2_i,
  input  mul_pkg::pp_row_t x3_i,
  output mul_pkg::pp_row_t sum_o,
  output mul_pkg::pp_row_t carry_o
);

  localparam int W = $bits(mul_pkg::pp_row_t);

  // first full adder sum and the carry passed to the next column
  logic s1;
  logic cout;
  // carry arriving from the column below
  logic cin;

  always_comb begin
    cin     = 1'b0;
    sum_o   = '0;
    carry_o = '0;
    for (int j = 0; j < W; j++) begin
      // first adder takes three rows
      s1   = x0_i[j] ^ x1_i[j] ^ x2_i[j];
      cout = (x0_i[j] & x1_i[j]) | (x0_i[j] & x2_i[j]) | (x1_i[j] & x2_i[j]);

      // second adder merges the fourth row and the incoming carry
      sum_o[j] = s1 ^ x3_i[j] ^ cin;

      // carry row leaves pre-shifted, top column overflows out of range
      if (j < W - 1) begin
        carry_o[j+1] = (s1 & x3_i[j]) | (s1 & cin) | (x3_i[j] & cin);
      end

      cin = cout;
    end
  end

endmodule

/* mul_csa_row52.sv */
module mul_csa_row52 (
  input  mul_pkg::pp_row_t x0_i,
  input  mul_pkg::pp_row_t x1_i,
  input  mul_pkg::pp_row_t x2_i,
  input  mul_pkg::pp_row_t x3_i,
  input  mul_pkg::pp_row_t x4_i,
  output mul_pkg::pp_row_t sum_o,
  output mul_pkg::pp_row_t carry_o
);

  localparam int W = $bits(mul_pkg::pp_row_t);

  // partial sums of the first two adders in a column
  logic s1;
  logic s2;
  // carries handed to the next column
  logic cout0;
  logic cout1;
  // carries from the column below
  logic cin0;
  logic cin1;

  always_comb begin
    cin0    = 1'b0;
    cin1    = 1'b0;
    sum_o   = '0;
    carry_o = '0;
    for (int j = 0; j < W; j++) begin
      // rows 0..2
      s1    = x0_i[j] ^ x1_i[j] ^ x2_i[j];
      cout0 = (x0_i[j] & x1_i[j]) | (x0_i[j] & x2_i[j]) | (x1_i[j] & x2_i[j]);

      // row 3 with the first lateral carry
      s2    = s1 ^ x3_i[j] ^ cin0;
      cout1 = (s1 & x3_i[j]) | (s1 & cin0) | (x3_i[j] & cin0);

      // row 4 with the second lateral carry
      sum_o[j] = s2 ^ x4_i[j] ^ cin1;
      if (j < W - 1) begin
        carry_o[j+1] = (s2 & x4_i[j]) | (s2 & cin1) | (x4_i[j] & cin1);
      end

      cin0 = cout0;
      cin1 = cout1;
    end
  end

endmodule

/* mul_wallace_tree.sv */
`include "mul_params.svh"

module mul_wallace_tree (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 in_valid_i,
  input  mul_pkg::pp_row_t [`MUL_PP_COUNT-1:0] pp_i,
  output logic                                 out_valid_o,
  output mul_pkg::product_t                    product_o
);

  // stage 1 holds the raw partial products
  mul_pkg::pp_row_t [`MUL_PP_COUNT-1:0] s1_q;
  // level one output, 17 rows down to 8
  mul_pkg::pp_row_t [7:0]               s2_d;
  mul_pkg::pp_row_t [7:0]               s2_q;
  // level two output, 8 down to 4
  mul_pkg::pp_row_t [3:0]               s3_d;
  mul_pkg::pp_row_t [3:0]               s3_q;
  // level three output, 4 down to 2
  mul_pkg::pp_row_t [1:0]               s4_d;
  mul_pkg::pp_row_t [1:0]               s4_q;
  // carry-propagate add of the last two rows
  mul_pkg::product_t                    final_sum;

  // one bit per stage, last bit is the output strobe
  logic [`MUL_PIPE_DEPTH-1:0]           valid_q;

  // level one: a 5-2 row on rows 0..4
  mul_csa_row52 u_l1_row52 (
    .x0_i    (s1_q[0]),
    .x1_i    (s1_q[1]),
    .x2_i    (s1_q[2]),
    .x3_i    (s1_q[3]),
    .x4_i    (s1_q[4]),
    .sum_o   (s2_d[0]),
    .carry_o (s2_d[1])
  );

  // then 4-2 rows on rows 5..16
  for (genvar k = 0; k < 3; k++) begin : g_l1_row42
    mul_csa_row42 u_row42 (
      .x0_i    (s1_q[5+4*k]),
      .x1_i    (s1_q[6+4*k]),
      .x2_i    (s1_q[7+4*k]),
      .x3_i    (s1_q[8+4*k]),
      .sum_o   (s2_d[2+2*k]),
      .carry_o (s2_d[3+2*k])
    );
  end

  // level two
  for (genvar k = 0; k < 2; k++) begin : g_l2_row42
    mul_csa_row42 u_row42 (
      .x0_i    (s2_q[4*k]),
      .x1_i    (s2_q[4*k+1]),
      .x2_i    (s2_q[4*k+2]),
      .x3_i    (s2_q[4*k+3]),
      .sum_o   (s3_d[2*k]),
      .carry_o (s3_d[2*k+1])
    );
  end

  // level three
  mul_csa_row42 u_l3_row42 (
    .x0_i    (s3_q[0]),
    .x1_i    (s3_q[1]),
    .x2_i    (s3_q[2]),
    .x3_i    (s3_q[3]),
    .sum_o   (s4_d[0]),
    .carry_o (s4_d[1])
  );

  assign final_sum = s4_q[0] + s4_q[1];

  // datapath stages run every cycle
  always_ff @(posedge clk) begin
    s1_q <= pp_i;
    s2_q <= s2_d;
    s3_q <= s3_d;
    s4_q <= s4_d;
    // result only changes when an operation reaches the last stage
    if (valid_q[`MUL_PIPE_DEPTH-2]) begin
      product_o <= final_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[`MUL_PIPE_DEPTH-2:0], in_valid_i};
    end
  end

  assign out_valid_o = valid_q[`MUL_PIPE_DEPTH-1];

endmodule

/* mul_top.sv */
module mul_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid_i,
  input  logic              rs1_signed_i,
  input  logic              rs2_signed_i,
  input  mul_pkg::operand_t rs1_i,
  input  mul_pkg::operand_t rs2_i,
  output logic              out_valid_o,
  output mul_pkg::product_t product_o
);

  // booth rows feeding the tree
  mul_pkg::pp_row_t [mul_pkg::PP_COUNT-1:0] pp;

  mul_booth_r4 u_booth (
    .rs1_signed_i (rs1_signed_i),
    .rs2_signed_i (rs2_signed_i),
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .pp_o         (pp)
  );

  // five-stage reduction and final add
  mul_wallace_tree u_tree (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .pp_i        (pp),
    .out_valid_o (out_valid_o),
    .product_o   (product_o)
  );

endmodule

/* mul_tb_asserts.sv */
module mul_tb_asserts (
  input logic              clk,
  input logic              rst,
  input logic              in_valid_i,
  input logic              out_valid_i,
  input mul_pkg::product_t product_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // valid chain is cleared by reset
  assert property (@(posedge clk) rst |=> !out_valid_i)
    else $error("out_valid_o high during reset");

  // fixed five-cycle latency, one result per strobe
  assert property (@(posedge clk) disable iff (rst)
                   out_valid_i == $past(in_valid_i, 5))
    else $error("out_valid_o does not follow in_valid_i five cycles later");

  assert property (@(posedge clk) disable iff (rst)
                   out_valid_i |-> !$isunknown(product_i))
    else $error("product_o has unknown bits while out_valid_o is high");

endmodule

bind mul_top mul_tb_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .in_valid_i  (in_valid_i),
  .out_valid_i (out_valid_o),
  .product_i   (product_o)
);

/* mul_tb.sv */
module mul_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // strobe to result, fixed by the pipeline
  localparam int LATENCY       = 5;
  localparam int DRAIN_TIMEOUT = 100;

  logic              clk;
  logic              rst;
  logic              in_valid_i;
  logic              rs1_signed_i;
  logic              rs2_signed_i;
  mul_pkg::operand_t rs1_i;
  mul_pkg::operand_t rs2_i;
  logic              out_valid_o;
  mul_pkg::product_t product_o;

  // expected results in issue order, with the cycle each strobe was seen
  mul_pkg::product_t  exp_q[$];
  int                 issue_q[$];
  int                 cyc;
  // out_valid_o predicted for the current cycle
  logic               exp_valid;

  mul_top uut (
    .clk          (clk),
    .rst          (rst),
    .in_valid_i   (in_valid_i),
    .rs1_signed_i (rs1_signed_i),
    .rs2_signed_i (rs2_signed_i),
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .out_valid_o  (out_valid_o),
    .product_o    (product_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reference product, operands extended by their own flag
  function automatic mul_pkg::product_t model_product(input logic sa, input logic sb,
                                                      input mul_pkg::operand_t a,
                                                      input mul_pkg::operand_t b);
    mul_pkg::product_t ea;
    mul_pkg::product_t eb;
    ea = sa ? {{32{a[31]}}, a} : {32'h0, a};
    eb = sb ? {{32{b[31]}}, b} : {32'h0, b};
    return ea * eb;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    string line;
    if (got !== exp) begin
      line = $sformatf("error at %0t: %s expected %h got %h", $time, name, exp, got);
      fail_now(line);
    end
  endtask

  task automatic issue_op(input logic sa, input logic sb,
                          input mul_pkg::operand_t a, input mul_pkg::operand_t b);
    @(posedge clk);
    in_valid_i   <= 1'b1;
    rs1_signed_i <= sa;
    rs2_signed_i <= sb;
    rs1_i        <= a;
    rs2_i        <= b;
    exp_q.push_back(model_product(sa, sb, a, b));
    // strobe becomes visible at the next falling edge
    issue_q.push_back(cyc + 1);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid_i <= 1'b0;
      // junk operands while idle
      rs1_i      <= $urandom;
      rs2_i      <= $urandom;
    end
  endtask

  task automatic random_ops(input int count, input logic sa, input logic sb, input int max_gap);
    int gap;
    for (int i = 0; i < count; i++) begin
      issue_op(sa, sb, $urandom, $urandom);
      gap = $urandom_range(0, max_gap);
      if (gap > 0) begin
        idle_cycles(gap);
      end
    end
  endtask

  task automatic corner_ops();
    mul_pkg::operand_t corners[5];
    corners[0] = 32'h0000_0000;
    corners[1] = 32'h0000_0001;
    corners[2] = 32'hffff_ffff;
    corners[3] = 32'h8000_0000;
    corners[4] = 32'h7fff_ffff;
    for (int mode = 0; mode < 4; mode++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          issue_op(mode[1], mode[0], corners[i], corners[j]);
        end
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
  endtask

  // outputs sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (!rst) begin
      // oldest outstanding operation is due exactly LATENCY cycles after its strobe
      exp_valid = (issue_q.size() != 0) && (cyc == issue_q[0] + LATENCY);
      check_value("out_valid_o", out_valid_o, exp_valid);
      if (out_valid_o) begin
        check_value("product_o", product_o, exp_q.pop_front());
        void'(issue_q.pop_front());
      end
    end
  end

  initial begin
    rst          = 1'b1;
    in_valid_i   = 1'b0;
    rs1_signed_i = 1'b0;
    rs2_signed_i = 1'b0;
    rs1_i        = '0;
    rs2_i        = '0;
    cyc          = 0;
    void'($urandom(32'hf413bb9a));

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // quiet stretch, no result may appear
    idle_cycles(10);
    random_ops(40, 1'b0, 1'b0, 3);
    random_ops(40, 1'b1, 1'b1, 3);
    random_ops(30, 1'b1, 1'b0, 3);
    random_ops(30, 1'b0, 1'b1, 3);
    corner_ops();
    idle_cycles(3);

    // back-to-back strobes keep five operations in flight
    for (int i = 0; i < 50; i++) begin
      issue_op($urandom_range(0, 1), $urandom_range(0, 1), $urandom, $urandom);
    end
    idle_cycles(1);

    wait_drain();
    if (exp_q.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_now("timed out waiting for results, some operations never completed");
    end
  end

endmodule

/* vlog.f */
+incdir+.
mul_pkg.sv
mul_booth_r4.sv
mul_csa_row42.sv
mul_csa_row52.sv
mul_wallace_tree.sv
mul_top.sv
mul_tb_asserts.sv
mul_tb.sv
